/* filelist.f */
hw/delay_pkg.sv
hw/stall_lfsr.sv
hw/channel_delay.sv
hw/outstanding_limiter.sv
hw/axi_write_delayer.sv
bench/write_responder.sv
bench/tb_axi_write_delayer.sv

/* bench/tb_axi_write_delayer.sv */
module tb_axi_write_delayer;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_WRITES   = 200;
  localparam int TIMEOUT      = 2000;
  localparam int STALL_WINDOW = 20;

  logic                         clk;
  logic                         rst_n;
  logic                         slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready;
  logic                         slv_w_last, slv_b_valid, slv_b_ready;
  logic                         mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready;
  logic                         mst_w_last, mst_b_valid, mst_b_ready;
  logic [delay_pkg::ID_W-1:0]   slv_aw_id, slv_b_id, mst_aw_id, mst_b_id;
  logic [delay_pkg::ADDR_W-1:0] slv_aw_addr, mst_aw_addr;
  logic [delay_pkg::DATA_W-1:0] slv_w_data, mst_w_data;
  logic [delay_pkg::STRB_W-1:0] slv_w_strb, mst_w_strb;
  logic [1:0]                   slv_b_resp, mst_b_resp;

  integer seed = 16;
  logic   b_hold;
  int     outstanding;
  int     slv_aw_cnt, slv_w_cnt, slv_b_cnt, mst_aw_cnt, mst_w_cnt, mst_b_cnt;

  // Beats in the order they have to come out on the far side
  delay_pkg::aw_t aw_q[$];
  delay_pkg::w_t  w_q[$];
  delay_pkg::b_t  b_q[$];
  delay_pkg::aw_t aw_seen;
  delay_pkg::w_t  w_seen;
  delay_pkg::b_t  b_seen;

  axi_write_delayer dut (.*);

  write_responder responder (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_valid (mst_aw_valid),
    .aw_ready (mst_aw_ready),
    .aw_id    (mst_aw_id),
    .aw_addr  (mst_aw_addr),
    .w_valid  (mst_w_valid),
    .w_ready  (mst_w_ready),
    .w_last   (mst_w_last),
    .b_valid  (mst_b_valid),
    .b_ready  (mst_b_ready),
    .b_id     (mst_b_id),
    .b_resp   (mst_b_resp)
  );

  always #5 clk = ~clk;

  // The manager takes B at random, except while the limit test holds it off
  always @(posedge clk) begin
    slv_b_ready <= !b_hold && (($random(seed) & 3) != 0);
  end

  // Reference model of the subordinate's answer to one write
  function automatic delay_pkg::b_t expected_b(delay_pkg::aw_t aw);
    delay_pkg::b_t b;
    b.id   = aw.id;
    b.resp = (aw.addr[1:0] == 2'b00) ? 2'b00 : 2'b10;
    return b;
  endfunction

  task automatic abort_run(string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_aw(delay_pkg::aw_t got, delay_pkg::aw_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0d ns: AW id %h addr %h, expected id %h addr %h",
                          $time, got.id, got.addr, exp.id, exp.addr));
    end
  endtask

  task automatic check_w(delay_pkg::w_t got, delay_pkg::w_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0d ns: W beat %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_b(delay_pkg::b_t got, delay_pkg::b_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0d ns: B id %h resp %0d, expected id %h resp %0d",
                          $time, got.id, got.resp, exp.id, exp.resp));
    end
  endtask

  task automatic compare_level(string what, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic compare_tally(string what, int got, int exp);
    if (got != exp) begin
      abort_run($sformatf("Error at %0d ns: %s saw %0d transfers, expected %0d",
                          $time, what, got, exp));
    end
  endtask

  task automatic drive_aw(int n);
    int waited;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      slv_aw_valid <= 1'b1;
      slv_aw_id    <= delay_pkg::ID_W'($random(seed));
      slv_aw_addr  <= delay_pkg::ADDR_W'($random(seed));
      waited = 0;
      // Ready is read mid-cycle, where it no longer moves before the edge
      do begin
        @(negedge clk);
        waited++;
        if (waited > TIMEOUT) abort_run("AW timed out: the delayer stopped accepting writes");
      end while (!slv_aw_ready);
    end
    @(posedge clk);
    slv_aw_valid <= 1'b0;
  endtask

  task automatic drive_w(int n);
    int waited;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      slv_w_valid <= 1'b1;
      slv_w_data  <= delay_pkg::DATA_W'($random(seed));
      slv_w_strb  <= delay_pkg::STRB_W'($random(seed));
      slv_w_last  <= 1'b1;
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
        if (waited > TIMEOUT) abort_run("W timed out: the delayer stopped accepting data");
      end while (!slv_w_ready);
    end
    @(posedge clk);
    slv_w_valid <= 1'b0;
  endtask

  // The scoreboard samples mid-cycle when every handshake signal has settled
  always @(negedge clk) begin
    if (rst_n) begin
      // Upstream AW sets both the AW to expect downstream and the B to expect back
      if (slv_aw_valid && slv_aw_ready) begin
        aw_seen.id   = slv_aw_id;
        aw_seen.addr = slv_aw_addr;
        aw_q.push_back(aw_seen);
        b_q.push_back(expected_b(aw_seen));
        slv_aw_cnt++;
      end
      if (slv_w_valid && slv_w_ready) begin
        w_seen.data = slv_w_data;
        w_seen.strb = slv_w_strb;
        w_seen.last = slv_w_last;
        w_q.push_back(w_seen);
        slv_w_cnt++;
      end
      if (mst_aw_valid && mst_aw_ready) begin
        if (aw_q.size() == 0) abort_run("An AW beat reached the subordinate that was never sent");
        aw_seen.id   = mst_aw_id;
        aw_seen.addr = mst_aw_addr;
        check_aw(aw_seen, aw_q.pop_front());
        mst_aw_cnt++;
        outstanding++;
      end
      if (mst_w_valid && mst_w_ready) begin
        if (w_q.size() == 0) abort_run("A W beat reached the subordinate that was never sent");
        w_seen.data = mst_w_data;
        w_seen.strb = mst_w_strb;
        w_seen.last = mst_w_last;
        check_w(w_seen, w_q.pop_front());
        mst_w_cnt++;
      end
      if (slv_b_valid && slv_b_ready) begin
        if (b_q.size() == 0) abort_run("A B response reached the manager with no write behind it");
        b_seen.id   = slv_b_id;
        b_seen.resp = slv_b_resp;
        check_b(b_seen, b_q.pop_front());
        slv_b_cnt++;
        outstanding--;
      end
      if (mst_b_valid && mst_b_ready) begin
        mst_b_cnt++;
      end
      if (outstanding > delay_pkg::MAX_OUTSTANDING) begin
        abort_run($sformatf("Error at %0d ns: %0d writes in flight, limit is %0d",
                            $time, outstanding, delay_pkg::MAX_OUTSTANDING));
      end
    end
  end

  initial begin
    int waited;
    int last_b;
    clk          = 1'b0;
    rst_n        = 1'b0;
    b_hold       = 1'b1;
    slv_aw_valid = 1'b0;
    slv_aw_id    = '0;
    slv_aw_addr  = '0;
    slv_w_valid  = 1'b0;
    slv_w_data   = '0;
    slv_w_strb   = '0;
    slv_w_last   = 1'b0;
    slv_b_ready  = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Idle state straight out of reset
    @(negedge clk);
    compare_level("slv_aw_ready", slv_aw_ready, 1'b1);
    compare_level("slv_w_ready", slv_w_ready, 1'b1);
    compare_level("mst_b_ready", mst_b_ready, 1'b1);
    compare_level("slv_b_valid", slv_b_valid, 1'b0);
    compare_level("mst_aw_valid", mst_aw_valid, 1'b0);
    compare_level("mst_w_valid", mst_w_valid, 1'b0);

    fork
      drive_aw(NUM_WRITES);
      drive_w(NUM_WRITES);
    join_none

    // The first writes go out with B held back, so the count climbs to the limit
    waited = 0;
    while (outstanding < delay_pkg::MAX_OUTSTANDING) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("Limit test timed out: writes in flight never hit the limit");
    end
    // At the limit no further AW may leave
    repeat (STALL_WINDOW) begin
      @(negedge clk);
      compare_level("mst_aw_valid at the limit", mst_aw_valid, 1'b0);
    end
    @(posedge clk);
    b_hold <= 1'b0;

    // Wait for every B, as long as responses keep coming
    waited = 0;
    last_b = slv_b_cnt;
    while (slv_b_cnt < NUM_WRITES) begin
      @(posedge clk);
      if (slv_b_cnt != last_b) begin
        waited = 0;
        last_b = slv_b_cnt;
      end else begin
        waited++;
      end
      if (waited > TIMEOUT) abort_run("B timed out: responses stopped reaching the manager");
    end

    compare_tally("slv AW", slv_aw_cnt, NUM_WRITES);
    compare_tally("slv W", slv_w_cnt, NUM_WRITES);
    compare_tally("slv B", slv_b_cnt, NUM_WRITES);
    compare_tally("mst AW", mst_aw_cnt, NUM_WRITES);
    compare_tally("mst W", mst_w_cnt, NUM_WRITES);
    compare_tally("mst B", mst_b_cnt, NUM_WRITES);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* bench/write_responder.sv */
module write_responder (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         aw_valid,
  output logic                         aw_ready,
  input  logic [delay_pkg::ID_W-1:0]   aw_id,
  input  logic [delay_pkg::ADDR_W-1:0] aw_addr,
  input  logic                         w_valid,
  output logic                         w_ready,
  input  logic                         w_last,
  output logic                         b_valid,
  input  logic                         b_ready,
  output logic [delay_pkg::ID_W-1:0]   b_id,
  output logic [1:0]                   b_resp
);

  timeunit 1ns;
  timeprecision 1ps;

  integer        seed = 16;
  int            lasts;
  delay_pkg::b_t entry;
  // Answers still owed with the oldest AW at the front
  delay_pkg::b_t pending[$];

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      b_valid  <= 1'b0;
      b_id     <= '0;
      b_resp   <= '0;
      lasts    = 0;
      pending.delete();
    end else begin
      // Ready comes up on about three cycles in four
      aw_ready <= (($random(seed) & 3) != 0);
      w_ready  <= (($random(seed) & 3) != 0);
      // Word-aligned writes get OKAY, the rest SLVERR
      if (aw_valid && aw_ready) begin
        entry.id   = aw_id;
        entry.resp = (aw_addr[1:0] == 2'b00) ? 2'b00 : 2'b10;
        pending.push_back(entry);
      end
      if (w_valid && w_ready && w_last) begin
        lasts++;
      end
      if (b_valid && b_ready) begin
        pending.delete(0);
        lasts--;
      end
      // A B needs both its AW and the closing W beat
      // A B that is already shown stays put until it is taken
      if ((!b_valid || b_ready) && (pending.size() > 0) && (lasts > 0)) begin
        b_valid <= 1'b1;
        b_id    <= pending[0].id;
        b_resp  <= pending[0].resp;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

endmodule

/* hw/axi_write_delayer.sv */
module axi_write_delayer (
  input  logic                           clk,
  input  logic                           rst_n,
  // Manager side
  input  logic                           slv_aw_valid,
  output logic                           slv_aw_ready,
  input  logic [delay_pkg::ID_W-1:0]     slv_aw_id,
  input  logic [delay_pkg::ADDR_W-1:0]   slv_aw_addr,
  input  logic                           slv_w_valid,
  output logic                           slv_w_ready,
  input  logic [delay_pkg::DATA_W-1:0]   slv_w_data,
  input  logic [delay_pkg::STRB_W-1:0]   slv_w_strb,
  input  logic                           slv_w_last,
  output logic                           slv_b_valid,
  input  logic                           slv_b_ready,
  output logic [delay_pkg::ID_W-1:0]     slv_b_id,
  output logic [1:0]                     slv_b_resp,
  // Subordinate side
  output logic                           mst_aw_valid,
  input  logic                           mst_aw_ready,
  output logic [delay_pkg::ID_W-1:0]     mst_aw_id,
  output logic [delay_pkg::ADDR_W-1:0]   mst_aw_addr,
  output logic                           mst_w_valid,
  input  logic                           mst_w_ready,
  output logic [delay_pkg::DATA_W-1:0]   mst_w_data,
  output logic [delay_pkg::STRB_W-1:0]   mst_w_strb,
  output logic                           mst_w_last,
  input  logic                           mst_b_valid,
  output logic                           mst_b_ready,
  input  logic [delay_pkg::ID_W-1:0]     mst_b_id,
  input  logic [1:0]                     mst_b_resp
);

  delay_pkg::aw_t slv_aw_pkt;
  delay_pkg::aw_t mst_aw_pkt;
  delay_pkg::w_t  slv_w_pkt;
  delay_pkg::w_t  mst_w_pkt;
  delay_pkg::b_t  mst_b_pkt;
  delay_pkg::b_t  slv_b_pkt;
  logic           aw_dly_valid;
  logic           aw_dly_ready;

  // Fields go in as structs and come out loose again
  assign slv_aw_pkt = '{id: slv_aw_id, addr: slv_aw_addr};
  assign slv_w_pkt  = '{data: slv_w_data, strb: slv_w_strb, last: slv_w_last};
  assign mst_b_pkt  = '{id: mst_b_id, resp: mst_b_resp};

  assign mst_aw_id   = mst_aw_pkt.id;
  assign mst_aw_addr = mst_aw_pkt.addr;
  assign mst_w_data  = mst_w_pkt.data;
  assign mst_w_strb  = mst_w_pkt.strb;
  assign mst_w_last  = mst_w_pkt.last;
  assign slv_b_id    = slv_b_pkt.id;
  assign slv_b_resp  = slv_b_pkt.resp;

  // The AW stage feeds the limiter that sits in front of the subordinate
  channel_delay #(
    .payload_t (delay_pkg::aw_t),
    .DELAY     (delay_pkg::AW_DELAY),
    .STALL     (delay_pkg::RANDOM_STALL),
    .SEED      (delay_pkg::AW_SEED)
  ) u_aw_delay (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (slv_aw_valid),
    .in_ready  (slv_aw_ready),
    .in_data   (slv_aw_pkt),
    .out_valid (aw_dly_valid),
    .out_ready (aw_dly_ready),
    .out_data  (mst_aw_pkt)
  );

  // The count drops when the manager takes a B, not when the subordinate sends it
  outstanding_limiter u_limiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .aw_valid    (aw_dly_valid),
    .aw_ready    (aw_dly_ready),
    .gated_valid (mst_aw_valid),
    .gated_ready (mst_aw_ready),
    .b_done      (slv_b_valid && slv_b_ready)
  );

  channel_delay #(
    .payload_t (delay_pkg::w_t),
    .DELAY     (delay_pkg::W_DELAY),
    .STALL     (delay_pkg::RANDOM_STALL),
    .SEED      (delay_pkg::W_SEED)
  ) u_w_delay (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (slv_w_valid),
    .in_ready  (slv_w_ready),
    .in_data   (slv_w_pkt),
    .out_valid (mst_w_valid),
    .out_ready (mst_w_ready),
    .out_data  (mst_w_pkt)
  );

  // B flows the other way from the subordinate back to the manager
  channel_delay #(
    .payload_t (delay_pkg::b_t),
    .DELAY     (delay_pkg::B_DELAY),
    .STALL     (delay_pkg::RANDOM_STALL),
    .SEED      (delay_pkg::B_SEED)
  ) u_b_delay (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (mst_b_valid),
    .in_ready  (mst_b_ready),
    .in_data   (mst_b_pkt),
    .out_valid (slv_b_valid),
    .out_ready (slv_b_ready),
    .out_data  (slv_b_pkt)
  );

endmodule

/* hw/outstanding_limiter.sv */
module outstanding_limiter (
  input  logic clk,
  input  logic rst_n,
  input  logic aw_valid,
  output logic aw_ready,
  output logic gated_valid,
  input  logic gated_ready,
  input  logic b_done
);

  localparam logic [delay_pkg::OUT_CNT_W-1:0] LIMIT =
    delay_pkg::OUT_CNT_W'(delay_pkg::MAX_OUTSTANDING);

  logic [delay_pkg::OUT_CNT_W-1:0] cnt;
  logic                            at_limit;
  logic                            inc;

  assign at_limit = (cnt == LIMIT);

  // The gating is pure logic so the AW path gets no extra cycle
  // The count only grows on a transfer, which means a waiting beat never sees valid fall
  assign gated_valid = aw_valid && !at_limit;
  assign aw_ready    = gated_ready && !at_limit;
  assign inc         = gated_valid && gated_ready;

  // The count goes up on a downstream AW and down on a B handed back upstream
  // Both in one cycle leave the count where it is
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      if (inc && !b_done) begin
        cnt <= cnt + 1'b1;
      end else if (b_done && !inc && (cnt != '0)) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    cnt <= LIMIT)
    else $error("outstanding count above the limit");

  // A B can only come back for a write that already went downstream
  assert property (@(posedge clk) disable iff (!rst_n)
    b_done |-> (cnt != '0))
    else $error("B response with no write outstanding");

endmodule

/* hw/channel_delay.sv */
module channel_delay #(
  parameter type payload_t = logic,
  parameter int unsigned DELAY = 0,
  parameter bit STALL = 1'b0,
  parameter logic [delay_pkg::LFSR_W-1:0] SEED = {{(delay_pkg::LFSR_W-1){1'b0}}, 1'b1}
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // Age counters need at least one bit even when no hold time is asked for
  localparam int AGE_W = (DELAY > 0) ? $clog2(DELAY + 1) : 1;
  localparam logic [AGE_W-1:0] AGE_MAX = AGE_W'(DELAY);

  payload_t         mem [2];
  logic [AGE_W-1:0] age [2];
  logic [1:0]       vld;
  logic             wr_ptr;
  logic             rd_ptr;
  logic             presented;
  logic             stall;
  logic             head_ready;
  logic             push;
  logic             pop;

  stall_lfsr #(
    .SEED   (SEED),
    .ENABLE (STALL)
  ) u_stall (
    .clk   (clk),
    .rst_n (rst_n),
    .stall (stall)
  );

  // Upstream only waits when both entries hold a beat
  assign in_ready = !(&vld);
  assign push     = in_valid && in_ready;

  // The head may leave once it has sat for DELAY cycles
  assign head_ready = vld[rd_ptr] && (age[rd_ptr] == AGE_MAX);

  // A stall only keeps a beat back before it is shown
  // Once valid is up it stays up until the transfer, as AXI requires
  assign out_valid = head_ready && (!stall || presented);
  assign out_data  = mem[rd_ptr];
  assign pop       = out_valid && out_ready;

  // Payload storage is written only into a free entry
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld       <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      presented <= 1'b0;
      age[0]    <= '0;
      age[1]    <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        // Each entry ages on its own, so a beat queued behind the head
        // also serves its hold time while it waits
        if (push && (wr_ptr == 1'(i))) begin
          vld[i] <= 1'b1;
          age[i] <= '0;
        end else begin
          if (pop && (rd_ptr == 1'(i))) begin
            vld[i] <= 1'b0;
          end
          if (vld[i] && (age[i] != AGE_MAX)) begin
            age[i] <= age[i] + 1'b1;
          end
        end
      end
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      // Remember that the head is on the bus so a later stall cannot pull it back
      presented <= out_valid && !out_ready;
    end
  end

  // A waiting beat holds both its valid and its payload
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("channel_delay output changed while stalled");

  // Pointer and flags must agree, so a write never lands on a live entry
  assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !vld[wr_ptr])
    else $error("channel_delay write into a full entry");

endmodule

/* hw/stall_lfsr.sv */
module stall_lfsr #(
  parameter logic [delay_pkg::LFSR_W-1:0] SEED = {{(delay_pkg::LFSR_W-1){1'b0}}, 1'b1},
  parameter bit ENABLE = 1'b1
) (
  input  logic clk,
  input  logic rst_n,
  output logic stall
);

  logic [delay_pkg::LFSR_W-1:0] lfsr;
  logic [delay_pkg::LFSR_W-1:0] lfsr_next;

  // Galois form that shifts right
  // The bit that falls out of the bottom folds back in through the tap mask
  always_comb begin
    lfsr_next = {1'b0, lfsr[delay_pkg::LFSR_W-1:1]};
    if (lfsr[0]) begin
      lfsr_next = lfsr_next ^ delay_pkg::LFSR_TAPS;
    end
  end

  // Runs freely from the seed, with no enable, so every stage sees its own sequence
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= SEED;
    end else begin
      lfsr <= lfsr_next;
    end
  end

  // Two low bits both set happens on roughly one cycle in four
  // With ENABLE cleared the stage never stalls
  assign stall = ENABLE && (lfsr[1:0] == 2'b11);

endmodule

/* hw/delay_pkg.sv */
package delay_pkg;

  // Widths of the write channel fields
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 8;
  localparam int STRB_W = 4;

  // Writes allowed past the delayer without a B coming back
  localparam int MAX_OUTSTANDING = 8;
  // Must be wide enough to hold MAX_OUTSTANDING itself
  localparam int OUT_CNT_W = 4;

  // Stall generator width and its feedback mask
  // Taps 16, 14, 13 and 11 give a maximal-length sequence
  localparam int LFSR_W = 16;
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

  // Fixed hold cycles added per channel on top of the one-cycle stage latency
  localparam int unsigned AW_DELAY = 0;
  localparam int unsigned W_DELAY  = 2;
  localparam int unsigned B_DELAY  = 1;

  // Random stalls on every stage when set
  localparam bit RANDOM_STALL = 1'b1;

  // One seed per channel so the stall patterns do not line up
  // An all-zero seed would lock the LFSR
  localparam logic [LFSR_W-1:0] AW_SEED = 16'hACE1;
  localparam logic [LFSR_W-1:0] W_SEED  = 16'h5EED;
  localparam logic [LFSR_W-1:0] B_SEED  = 16'h1D2B;

  // Channel payloads as carried through the delay stages
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_t;

endpackage
